//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// core geometry
`define CPU_XLEN      32
`define CPU_NREGS     32

// first fetch address after reset
`define CPU_RESET_PC  32'h0000_0000

`endif

//--- isa_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package isa_pkg;

    typedef logic [`CPU_XLEN-1:0]          word_t;
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

endpackage

`default_nettype wire

//--- ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI // passes the upper immediate through
    } alu_op_t;

    typedef enum logic {
        WB_ALU,
        WB_LOAD
    } wb_sel_t;

endpackage

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module fetch_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_grant,
    input  logic           id_stall,
    input  logic           branch_taken,
    input  isa_pkg::word_t branch_target,
    input  isa_pkg::word_t mem_rdata,
    output logic           fetch_req,
    output isa_pkg::word_t fetch_addr,
    output logic           id_valid,
    output isa_pkg::word_t id_pc,
    output isa_pkg::word_t id_inst
);
    import isa_pkg::*;

    word_t pc;
    word_t redir_target;
    logic  redir_pend;   // branch seen but delay slot not fetched yet

    assign fetch_req  = !id_stall;
    assign fetch_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= `CPU_RESET_PC;
            id_valid   <= 1'b0;
            redir_pend <= 1'b0;
        end else if (!id_stall) begin
            id_valid <= fetch_grant; // no grant means a bubble
            if (fetch_grant) begin
                if (branch_taken) begin
                    pc <= branch_target; // delay slot fetched this cycle
                end else if (redir_pend) begin
                    pc <= redir_target;
                end else begin
                    pc <= pc + 32'd4;
                end
                redir_pend <= 1'b0;
            end else if (branch_taken) begin
                redir_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (branch_taken) begin
            redir_target <= branch_target;
        end
        if (!id_stall && fetch_grant) begin
            id_pc   <= pc;
            id_inst <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module decode_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               id_valid,
    input  isa_pkg::word_t     id_pc,
    input  isa_pkg::word_t     id_inst,
    input  isa_pkg::reg_idx_t  ex_wreg,
    input  isa_pkg::reg_idx_t  mem_wreg,
    input  isa_pkg::reg_idx_t  wb_wreg,
    input  logic               ex_regwen,
    input  logic               ex_load,
    input  logic               mem_regwen,
    input  logic               wb_regwen,
    input  isa_pkg::word_t     wb_wdata,
    output logic               id_stall,
    output logic               branch_taken,
    output isa_pkg::word_t     branch_target,
    output logic               ex_valid,
    output isa_pkg::word_t     ex_pc,
    output isa_pkg::word_t     ex_a,
    output isa_pkg::word_t     ex_b,
    output isa_pkg::word_t     ex_imm,
    output isa_pkg::reg_idx_t  ex_rs,
    output isa_pkg::reg_idx_t  ex_rt,
    output ctrl_pkg::alu_op_t  ex_alu_op,
    output logic               ex_use_imm,
    output logic               ex_store,
    output ctrl_pkg::wb_sel_t  ex_wb_sel
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    word_t    rf [`CPU_NREGS];
    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm_ext;
    alu_op_t  alu_op;
    wb_sel_t  wb_sel;
    logic     dec_ok;
    logic     use_imm;
    logic     is_store;
    logic     is_beq;
    logic     uses_rt;
    logic     load_use;
    logic     branch_hazard;

    assign opcode = opcode_t'(id_inst[31:26]);
    assign funct  = funct_t'(id_inst[5:0]);
    assign rs     = id_inst[25:21];
    assign rt     = id_inst[20:16];

    always_comb begin
        dec_ok   = 1'b1;
        alu_op   = ALU_ADD;
        use_imm  = 1'b1;
        is_store = 1'b0;
        is_beq   = 1'b0;
        uses_rt  = 1'b0;
        wb_sel   = WB_ALU;
        imm_ext  = {{16{id_inst[15]}}, id_inst[15:0]}; // sign extend keeps rd in [15:11]
        case (opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                uses_rt = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: dec_ok = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_ORI: begin
                alu_op  = ALU_OR;
                imm_ext = {16'b0, id_inst[15:0]};
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;
                imm_ext = {id_inst[15:0], 16'b0};
            end
            OP_LW: wb_sel = WB_LOAD;
            OP_SW: begin
                is_store = 1'b1;
                uses_rt  = 1'b1;
            end
            OP_BEQ: begin
                is_beq  = 1'b1;
                uses_rt = 1'b1;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    // write first so WB is visible in ID
    assign rs_val = (rs == '0) ? '0 : (wb_regwen && wb_wreg == rs) ? wb_wdata : rf[rs];
    assign rt_val = (rt == '0) ? '0 : (wb_regwen && wb_wreg == rt) ? wb_wdata : rf[rt];

    always_ff @(posedge clk) begin
        if (wb_regwen) begin
            rf[wb_wreg] <= wb_wdata;
        end
    end

    assign load_use      = ex_load && (ex_wreg == rs || (uses_rt && ex_wreg == rt));
    assign branch_hazard = is_beq &&
                           ((ex_regwen && (ex_wreg == rs || ex_wreg == rt)) ||
                            (mem_regwen && (mem_wreg == rs || mem_wreg == rt)));
    assign id_stall      = id_valid && (load_use || branch_hazard);

    assign branch_taken  = id_valid && is_beq && !id_stall && (rs_val == rt_val);
    assign branch_target = id_pc + 32'd4 + {imm_ext[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid && dec_ok && !is_beq && !id_stall; // beq ends in ID
        end
    end

    always_ff @(posedge clk) begin
        ex_pc      <= id_pc;
        ex_a       <= rs_val;
        ex_b       <= rt_val;
        ex_imm     <= imm_ext;
        ex_rs      <= rs;
        ex_rt      <= rt;
        ex_alu_op  <= alu_op;
        ex_use_imm <= use_imm;
        ex_store   <= is_store;
        ex_wb_sel  <= wb_sel;
    end

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               ex_valid,
    input  isa_pkg::word_t     ex_pc,
    input  isa_pkg::word_t     ex_a,
    input  isa_pkg::word_t     ex_b,
    input  isa_pkg::word_t     ex_imm,
    input  isa_pkg::reg_idx_t  ex_rs,
    input  isa_pkg::reg_idx_t  ex_rt,
    input  ctrl_pkg::alu_op_t  ex_alu_op,
    input  logic               ex_use_imm,
    input  logic               ex_store,
    input  ctrl_pkg::wb_sel_t  ex_wb_sel,
    input  isa_pkg::word_t     mem_result,
    input  isa_pkg::word_t     wb_wdata,
    input  isa_pkg::reg_idx_t  mem_wreg,
    input  isa_pkg::reg_idx_t  wb_wreg,
    input  logic               mem_regwen,
    input  logic               wb_regwen,
    output isa_pkg::reg_idx_t  ex_wreg,
    output logic               ex_regwen,
    output logic               ex_load,
    output logic               mem_valid,
    output logic               mem_load,
    output logic               mem_store,
    output logic               mem_regwen_o,
    output isa_pkg::word_t     mem_alu_res,
    output isa_pkg::word_t     mem_store_data,
    output isa_pkg::word_t     mem_pc
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    word_t op_a;
    word_t fwd_b;
    word_t op_b;
    word_t alu_res;

    // MEM beats WB
    assign op_a = (mem_regwen && mem_wreg == ex_rs) ? mem_result :
                  (wb_regwen && wb_wreg == ex_rs)   ? wb_wdata   : ex_a;
    assign fwd_b = (mem_regwen && mem_wreg == ex_rt) ? mem_result :
                   (wb_regwen && wb_wreg == ex_rt)   ? wb_wdata   : ex_b;
    assign op_b = ex_use_imm ? ex_imm : fwd_b;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_LUI: alu_res = op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    assign ex_wreg   = ex_use_imm ? ex_rt : ex_imm[15:11]; // rd for R-type
    assign ex_regwen = ex_valid && !ex_store;
    assign ex_load   = ex_valid && (ex_wb_sel == WB_LOAD);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_load       <= (ex_wb_sel == WB_LOAD);
        mem_store      <= ex_store;
        mem_regwen_o   <= !ex_store;
        mem_alu_res    <= alu_res;
        mem_store_data <= fwd_b; // forwarded rt for sw
        mem_pc         <= ex_pc;
    end

endmodule

`default_nettype wire

//--- mem_wb_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mem_wb_unit (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::reg_idx_t  ex_wreg,
    input  logic               mem_valid,
    input  logic               mem_load,
    input  logic               mem_store,
    input  logic               mem_regwen_o,
    input  isa_pkg::word_t     mem_alu_res,
    input  isa_pkg::word_t     mem_store_data,
    input  isa_pkg::word_t     mem_pc,
    input  logic               data_grant,
    input  isa_pkg::word_t     mem_rdata,
    output logic               data_req,
    output logic               data_we,
    output isa_pkg::word_t     data_addr,
    output isa_pkg::word_t     data_wdata,
    output isa_pkg::reg_idx_t  mem_wreg,
    output logic               mem_regwen,
    output isa_pkg::word_t     mem_result,
    output logic               wb_regwen,
    output isa_pkg::reg_idx_t  wb_wreg,
    output isa_pkg::word_t     wb_wdata,
    output isa_pkg::word_t     wb_pc
);

    assign data_req   = mem_valid && (mem_load || mem_store);
    assign data_we    = mem_valid && mem_store;
    assign data_addr  = mem_alu_res;
    assign data_wdata = mem_store_data;

    assign mem_regwen = mem_valid && mem_regwen_o && (mem_wreg != '0); // r0 never written
    assign mem_result = mem_alu_res;

    always_ff @(posedge clk) begin
        mem_wreg <= ex_wreg; // destination half of EX/MEM
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_regwen <= 1'b0;
        end else begin
            wb_regwen <= mem_regwen;
        end
    end

    always_ff @(posedge clk) begin
        wb_wreg  <= mem_wreg;
        wb_pc    <= mem_pc;
        wb_wdata <= (mem_load && data_grant) ? mem_rdata : mem_alu_res;
    end

    a_data_granted: assert property (@(posedge clk) disable iff (rst)
        data_req |-> data_grant)
        else $error("memory stage request not granted");

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  logic           fetch_req,
    input  isa_pkg::word_t fetch_addr,
    input  logic           data_req,
    input  logic           data_we,
    input  isa_pkg::word_t data_addr,
    input  isa_pkg::word_t data_wdata,
    output logic           fetch_grant,
    output logic           data_grant,
    output logic           mem_req,
    output logic           mem_we,
    output isa_pkg::word_t mem_addr,
    output isa_pkg::word_t mem_wdata
);

    assign data_grant  = data_req;              // lw/sw always wins
    assign fetch_grant = fetch_req && !data_req;

    assign mem_req   = data_req || fetch_req;
    assign mem_we    = data_grant && data_we;
    assign mem_addr  = data_grant ? data_addr : fetch_addr;
    assign mem_wdata = data_wdata;

endmodule

`default_nettype wire

//--- mips_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core_top (
    input  logic              clk,
    input  logic              rst,
    output logic              mem_req,
    output logic              mem_we,
    output isa_pkg::word_t    mem_addr,
    output isa_pkg::word_t    mem_wdata,
    input  isa_pkg::word_t    mem_rdata,
    output isa_pkg::word_t    debug_wb_pc,
    output logic              debug_wb_rf_wen,
    output isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output isa_pkg::word_t    debug_wb_rf_wdata
);
    import isa_pkg::*;

    logic     fetch_req, fetch_grant, id_stall, branch_taken, id_valid;
    word_t    fetch_addr, branch_target, id_pc, id_inst;
    logic     ex_valid, ex_use_imm, ex_store, ex_regwen, ex_load;
    word_t    ex_pc, ex_a, ex_b, ex_imm;
    reg_idx_t ex_rs, ex_rt, ex_wreg;
    ctrl_pkg::alu_op_t ex_alu_op;
    ctrl_pkg::wb_sel_t ex_wb_sel;
    logic     mem_valid, mem_load, mem_store, mem_regwen_o, mem_regwen;
    word_t    mem_alu_res, mem_store_data, mem_pc, mem_result;
    reg_idx_t mem_wreg;
    logic     data_req, data_we, data_grant;
    word_t    data_addr, data_wdata;

    fetch_unit u_fetch_unit (
        .clk(clk), .rst(rst), .fetch_grant(fetch_grant), .id_stall(id_stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .mem_rdata(mem_rdata), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .id_valid(id_valid), .id_pc(id_pc), .id_inst(id_inst)
    );

    decode_unit u_decode_unit (
        .clk(clk), .rst(rst), .id_valid(id_valid), .id_pc(id_pc), .id_inst(id_inst),
        .ex_wreg(ex_wreg), .mem_wreg(mem_wreg), .wb_wreg(debug_wb_rf_wnum),
        .ex_regwen(ex_regwen), .ex_load(ex_load), .mem_regwen(mem_regwen),
        .wb_regwen(debug_wb_rf_wen), .wb_wdata(debug_wb_rf_wdata),
        .id_stall(id_stall), .branch_taken(branch_taken), .branch_target(branch_target),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm),
        .ex_store(ex_store), .ex_wb_sel(ex_wb_sel)
    );

    execute_unit u_execute_unit (
        .clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_a(ex_a),
        .ex_b(ex_b), .ex_imm(ex_imm), .ex_rs(ex_rs), .ex_rt(ex_rt),
        .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_store(ex_store),
        .ex_wb_sel(ex_wb_sel), .mem_result(mem_result), .wb_wdata(debug_wb_rf_wdata),
        .mem_wreg(mem_wreg), .wb_wreg(debug_wb_rf_wnum), .mem_regwen(mem_regwen),
        .wb_regwen(debug_wb_rf_wen), .ex_wreg(ex_wreg), .ex_regwen(ex_regwen),
        .ex_load(ex_load), .mem_valid(mem_valid), .mem_load(mem_load),
        .mem_store(mem_store), .mem_regwen_o(mem_regwen_o), .mem_alu_res(mem_alu_res),
        .mem_store_data(mem_store_data), .mem_pc(mem_pc)
    );

    mem_wb_unit u_mem_wb_unit (
        .clk(clk), .rst(rst), .ex_wreg(ex_wreg), .mem_valid(mem_valid),
        .mem_load(mem_load), .mem_store(mem_store), .mem_regwen_o(mem_regwen_o),
        .mem_alu_res(mem_alu_res), .mem_store_data(mem_store_data), .mem_pc(mem_pc),
        .data_grant(data_grant), .mem_rdata(mem_rdata), .data_req(data_req),
        .data_we(data_we), .data_addr(data_addr), .data_wdata(data_wdata),
        .mem_wreg(mem_wreg), .mem_regwen(mem_regwen), .mem_result(mem_result),
        .wb_regwen(debug_wb_rf_wen), .wb_wreg(debug_wb_rf_wnum),
        .wb_wdata(debug_wb_rf_wdata), .wb_pc(debug_wb_pc)
    );

    mem_arbiter u_mem_arbiter (
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .data_req(data_req),
        .data_we(data_we), .data_addr(data_addr), .data_wdata(data_wdata),
        .fetch_grant(fetch_grant), .data_grant(data_grant), .mem_req(mem_req),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

endmodule

`default_nettype wire

//--- tb_mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;
    import isa_pkg::*;

    localparam int pat_words    = 128;
    localparam int count_word   = 64;
    localparam int trace_base   = 65;
    localparam int quiet_cycles = 16;

    logic     clk;
    logic     rst;
    logic     mem_req;
    logic     mem_we;
    word_t    mem_addr;
    word_t    mem_wdata;
    word_t    mem_rdata;
    word_t    debug_wb_pc;
    logic     debug_wb_rf_wen;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    word_t pat [0:pat_words-1]; // image, count, expected trace
    word_t mem [0:63];

    int exp_count      = 0;
    int wb_count       = 0;
    int error_count    = 0;
    int check_count    = 0;
    int cur_group      = 0;
    int group_wbs      = 0;
    int group_err_base = 0;
    int cycles         = 0;
    int cycle_limit    = 0;
    int final_err_base = 0;
    int final_errs     = 0;
    int trace_idx      = 0;
    int wb_tag         = 0;
    bit trace_done     = 1'b0;

    mips_core_top i_mips_core_top (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    assign mem_rdata = mem[mem_addr[7:2]]; // combinational read, 64 words

    always @(posedge clk) begin
        if (mem_req && mem_we) begin
            mem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_group(input int group);
        $display("group %0d done: %0d writebacks, %0d errors",
                 group, group_wbs, error_count - group_err_base);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // trace checker, one triple per writeback
    always @(posedge clk) begin
        if (!rst && debug_wb_rf_wen === 1'b1) begin
            if (wb_count < exp_count) begin
                trace_idx = trace_base + 3 * wb_count;
                wb_tag    = int'(pat[trace_idx + 1][31:24]); // group number in top byte
                if (wb_tag != cur_group) begin
                    if (cur_group != 0) begin
                        report_group(cur_group);
                    end
                    cur_group      = wb_tag;
                    group_wbs      = 0;
                    group_err_base = error_count;
                end
                check_value("debug_wb_pc", debug_wb_pc, pat[trace_idx]);
                check_value("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum),
                            word_t'(pat[trace_idx + 1][4:0]));
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, pat[trace_idx + 2]);
                group_wbs++;
                wb_count++;
                if (wb_count == exp_count) begin
                    report_group(cur_group);
                    trace_done = 1'b1;
                end
            end else begin
                error_count++;
                wb_count++;
                $display("unexpected writeback after the last expected one at %0t: pc %h, r%0d",
                         $time, debug_wb_pc, debug_wb_rf_wnum);
            end
        end
    end

    initial begin
        rst = 1'b1;
        $readmemh("core_patterns.mem", pat);
        for (int i = 0; i < 64; i++) begin
            mem[i] = pat[i];
        end
        exp_count   = int'(pat[count_word]);
        cycle_limit = exp_count * 8 + 50;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (!trace_done && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!trace_done) begin
            error_count++;
            final_errs = 1;
            $display("timeout: trace did not complete after %0d cycles, %0d of %0d writebacks seen",
                     cycles, wb_count, exp_count);
        end else begin
            final_err_base = error_count;
            repeat (quiet_cycles) @(negedge clk); // core idles in its branch loop
            final_errs = error_count - final_err_base;
        end
        $display("group 6 done: %0d of %0d writebacks, %0d errors",
                 wb_count, exp_count, final_errs);
        $display("%0d writebacks, %0d checks, %0d errors", wb_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- core_patterns.mem
// words 0-63: program and data image, word 64: expected writeback count
// then one line per writeback: pc, group << 24 | register, data
@00
34010007 34020003 00221821 00612023 00832824 00A43025 00C1382A // r-type chain
2408FFF6 34098001 3C0A8765 354A4321 0107582A 254CFFFF          // immediates
340D00C0 ADAA0000 8DAE0000 01C27821                            // sw, lw, load-use addu
11EE0003 25F00001 10860002 24110011 24120BAD 26330001          // beq not taken, taken
26600055 0013A021 0000A825                                     // writes to r0
1000FFFF 00000000                                              // idle loop and slot
@40
00000015
00000000 01000001 00000007
00000004 01000002 00000003
00000008 01000003 0000000A
0000000C 01000004 00000003
00000010 01000005 00000002
00000014 01000006 00000003
00000018 01000007 00000001
0000001C 02000008 FFFFFFF6
00000020 02000009 00008001
00000024 0200000A 87650000
00000028 0200000A 87654321
0000002C 0200000B 00000001
00000030 0200000C 87654320
00000034 0300000D 000000C0
0000003C 0300000E 87654321
00000040 0300000F 87654324
00000048 04000010 87654325
00000050 04000011 00000011
00000058 04000013 00000012
00000060 05000014 00000012
00000064 05000015 00000000

//--- sim.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
mem_wb_unit.sv
mem_arbiter.sv
mips_core_top.sv
tb_mips_core.sv
